// ==== src/matrixPkg.sv ====
// ==========================================================
// Matrix ALU sizes, element and matrix types, opcode and
// alteration enums, and the row-major bus conversion
// ==========================================================
package matrixPkg;

	localparam int ElemWidth      = 16;
	localparam int MatrixDim      = 4;
	localparam int BusWidth       = ElemWidth * MatrixDim * MatrixDim;
	localparam int ScaleBitsWidth = 3;

	typedef logic [ElemWidth-1:0] elem_t;
	typedef elem_t [MatrixDim-1:0][MatrixDim-1:0] matrix_t;

	typedef enum logic [2:0] {
		NO_OP     = 3'b000,
		LOAD      = 3'b001,
		ADD       = 3'b010,
		SUB       = 3'b011,
		SCAL_MUL  = 3'b100,
		MATR_MUL  = 3'b101,
		TRANSPOSE = 3'b110,
		START     = 3'b111
	} opcode_e;

	// for SCAL_MUL the alteration field is reused as the top two scale bits
	typedef enum logic [1:0] {
		C_TO_A     = 2'b00,
		WRITE_A    = 2'b01,
		WRITE_B    = 2'b10,
		OUT_TO_BUS = 2'b11
	} alt_e;

	// row-major packing, element [0][0] sits in the top bits of the bus word
	function automatic int elemLsb(input int row, input int col);
		return BusWidth - ElemWidth * (row * MatrixDim + col + 1);
	endfunction

	function automatic matrix_t busToMatrix(input logic [BusWidth-1:0] bus);
		matrix_t m;
		for (int r = 0; r < MatrixDim; r++) begin
			for (int c = 0; c < MatrixDim; c++) begin
				m[r][c] = bus[elemLsb(r, c) +: ElemWidth];
			end
		end
		return m;
	endfunction

	function automatic logic [BusWidth-1:0] matrixToBus(input matrix_t m);
		logic [BusWidth-1:0] bus;
		for (int r = 0; r < MatrixDim; r++) begin
			for (int c = 0; c < MatrixDim; c++) begin
				bus[elemLsb(r, c) +: ElemWidth] = m[r][c];
			end
		end
		return bus;
	endfunction

endpackage

// ==== src/matrixMultiply.sv ====
// ==========================================================
// Full 4x4 matrix product of A and B as sixteen dot products
// ==========================================================
`timescale 1ns/1ps

module matrixMultiply (
	input  matrixPkg::matrix_t regA,
	input  matrixPkg::matrix_t regB,
	output matrixPkg::matrix_t productResult
);
	import matrixPkg::*;

	// one row of a against one column of b, the sum wraps at 16 bits
	function automatic elem_t dotProduct(
		input matrix_t a,
		input matrix_t b,
		input int      row,
		input int      col
	);
		elem_t acc;
		acc = '0;
		for (int k = 0; k < MatrixDim; k++) begin
			acc = acc + a[row][k] * b[k][col];
		end
		return acc;
	endfunction

	for (genvar r = 0; r < MatrixDim; r++) begin : gRow
		for (genvar c = 0; c < MatrixDim; c++) begin : gCol
			assign productResult[r][c] = dotProduct(regA, regB, r, c);
		end
	end

endmodule

// ==== src/matrixElementwise.sv ====
// ==========================================================
// Element-wise datapath: add, subtract, scalar multiply and
// transpose of A, plus the scale factor for SCAL_MUL
// ==========================================================
`timescale 1ns/1ps

module matrixElementwise (
	input  matrixPkg::opcode_e                   opCode,
	input  matrixPkg::alt_e                      alt,
	input  logic [matrixPkg::ScaleBitsWidth-1:0] scaleBits,
	input  matrixPkg::matrix_t                   regA,
	input  matrixPkg::matrix_t                   regB,
	output matrixPkg::matrix_t                   elementResult,
	output matrixPkg::elem_t                     scaleFactor
);
	import matrixPkg::*;

	localparam int PadWidth = ElemWidth - $bits(alt_e) - ScaleBitsWidth;

	// five scale bits give a factor between 0 and 31
	assign scaleFactor = {{PadWidth{1'b0}}, alt, scaleBits};

	always_comb begin
		elementResult = '0;
		for (int r = 0; r < MatrixDim; r++) begin
			for (int c = 0; c < MatrixDim; c++) begin
				// all results wrap at 16 bits
				case (opCode)
					ADD: begin
						elementResult[r][c] = regA[r][c] + regB[r][c];
					end
					SUB: begin
						elementResult[r][c] = regA[r][c] - regB[r][c];
					end
					SCAL_MUL: begin
						elementResult[r][c] = regA[r][c] * scaleFactor;
					end
					TRANSPOSE: begin
						elementResult[r][c] = regA[c][r];
					end
					default: begin
						elementResult[r][c] = '0;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/matrixRegisterBank.sv ====
// ==========================================================
// A, B and C matrix registers with command decode, result
// selection, scaled identity forming and the output flag
// ==========================================================
`timescale 1ns/1ps

module matrixRegisterBank (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           enable,
	input  matrixPkg::opcode_e             opCode,
	input  matrixPkg::alt_e                alt,
	input  logic [matrixPkg::BusWidth-1:0] dataIn,
	input  matrixPkg::matrix_t             elementResult,
	input  matrixPkg::matrix_t             productResult,
	input  matrixPkg::elem_t               scaleFactor,
	output matrixPkg::matrix_t             regA,
	output matrixPkg::matrix_t             regB,
	output logic [matrixPkg::BusWidth-1:0] dataOut,
	output logic                           outValid
);
	import matrixPkg::*;

	matrix_t regC;
	matrix_t scaledIdentity;
	matrix_t mathResult;
	logic    outValidNext;

	// diagonal carries the scale, everything else is zero
	always_comb begin
		scaledIdentity = '0;
		for (int i = 0; i < MatrixDim; i++) begin
			scaledIdentity[i][i] = scaleFactor;
		end
	end

	assign mathResult = (opCode == MATR_MUL) ? productResult : elementResult;

	// operand registers only change on LOAD and SCAL_MUL
	always_ff @(posedge clk) begin
		if (enable) begin
			case (opCode)
				LOAD: begin
					case (alt)
						WRITE_A: regA <= busToMatrix(dataIn);
						WRITE_B: regB <= busToMatrix(dataIn);
						C_TO_A:  regA <= regC;
						default: ;
					endcase
				end
				SCAL_MUL: regB <= scaledIdentity;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regC <= '0;
		end else if (enable) begin
			case (opCode)
				ADD, SUB, SCAL_MUL, MATR_MUL, TRANSPOSE: regC <= mathResult;
				default: ;
			endcase
		end
	end

	// SCAL_MUL, NO_OP and START never present a result on the bus
	always_comb begin
		case (opCode)
			LOAD, ADD, SUB, MATR_MUL, TRANSPOSE: outValidNext = enable && (alt == OUT_TO_BUS);
			default: outValidNext = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= outValidNext;
		end
	end

	// the bus always mirrors C, outValid tells when it is meant to be taken
	assign dataOut = matrixToBus(regC);

endmodule

// ==== src/matrixAlu.sv ====
// ==========================================================
// Matrix ALU top level: register bank and the two
// combinational datapaths
// ==========================================================
`timescale 1ns/1ps

module matrixAlu (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 enable,
	input  matrixPkg::opcode_e                   opCode,
	input  matrixPkg::alt_e                      alt,
	input  logic [matrixPkg::ScaleBitsWidth-1:0] scaleBits,
	input  logic [matrixPkg::BusWidth-1:0]       dataIn,
	output logic [matrixPkg::BusWidth-1:0]       dataOut,
	output logic                                 outValid
);
	import matrixPkg::*;

	matrix_t regA;
	matrix_t regB;
	matrix_t elementResult;
	matrix_t productResult;
	elem_t   scaleFactor;

	matrixRegisterBank registerBank_i (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.opCode        (opCode),
		.alt           (alt),
		.dataIn        (dataIn),
		.elementResult (elementResult),
		.productResult (productResult),
		.scaleFactor   (scaleFactor),
		.regA          (regA),
		.regB          (regB),
		.dataOut       (dataOut),
		.outValid      (outValid)
	);

	// both datapaths see the same A and B and settle within the cycle
	matrixElementwise elementwise_i (
		.opCode        (opCode),
		.alt           (alt),
		.scaleBits     (scaleBits),
		.regA          (regA),
		.regB          (regB),
		.elementResult (elementResult),
		.scaleFactor   (scaleFactor)
	);

	matrixMultiply multiply_i (
		.regA          (regA),
		.regB          (regB),
		.productResult (productResult)
	);

endmodule

// ==== tb/matrixAluChecker.sv ====
// ==========================================================
// Matrix ALU checker: reference model of A, B and C,
// output comparison and per-test reporting
// ==========================================================
`timescale 1ns/1ps

module matrixAluChecker (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 enable,
	input  matrixPkg::opcode_e                   opCode,
	input  matrixPkg::alt_e                      alt,
	input  logic [matrixPkg::ScaleBitsWidth-1:0] scaleBits,
	input  logic [matrixPkg::BusWidth-1:0]       dataIn,
	input  logic [matrixPkg::BusWidth-1:0]       dataOut,
	input  logic                                 outValid,
	input  logic                                 testEnd,
	input  int                                   testIndex,
	input  logic                                 finished,
	output int                                   errorCount
);
	import matrixPkg::*;

	matrix_t modelA;
	matrix_t modelB;
	matrix_t modelC;
	matrix_t nextA;
	matrix_t nextB;
	matrix_t nextC;
	logic    expValid;
	logic    nextValid;
	int      testErrors;
	int      testsPassed;
	int      testsFailed;

	// one clock edge of the command rules applied to the model registers
	function automatic void referenceStep(
		input  logic                      en,
		input  opcode_e                   op,
		input  alt_e                      al,
		input  logic [ScaleBitsWidth-1:0] sb,
		input  logic [BusWidth-1:0]       bus,
		input  matrix_t                   curA,
		input  matrix_t                   curB,
		input  matrix_t                   curC,
		output matrix_t                   newA,
		output matrix_t                   newB,
		output matrix_t                   newC,
		output logic                      valid
	);
		elem_t factor;
		int    acc;
		newA   = curA;
		newB   = curB;
		newC   = curC;
		factor = {11'd0, al, sb};
		valid  = en && (al == OUT_TO_BUS) && (op inside {LOAD, ADD, SUB, MATR_MUL, TRANSPOSE});
		if (en && (op == LOAD)) begin
			case (al)
				WRITE_A: newA = busToMatrix(bus);
				WRITE_B: newB = busToMatrix(bus);
				C_TO_A:  newA = curC;
				default: ;
			endcase
		end
		for (int r = 0; r < MatrixDim; r++) begin
			for (int c = 0; c < MatrixDim; c++) begin
				acc = 0;
				for (int k = 0; k < MatrixDim; k++) begin
					acc = acc + int'(curA[r][k]) * int'(curB[k][c]);
				end
				if (en) begin
					case (op)
						ADD:       newC[r][c] = curA[r][c] + curB[r][c];
						SUB:       newC[r][c] = curA[r][c] - curB[r][c];
						MATR_MUL:  newC[r][c] = acc[15:0];
						TRANSPOSE: newC[r][c] = curA[c][r];
						SCAL_MUL: begin
							newC[r][c] = curA[r][c] * factor;
							newB[r][c] = (r == c) ? factor : '0;
						end
						default: ;
					endcase
				end
			end
		end
	endfunction

	function automatic string testName(input int idx);
		case (idx)
			0: return "reset output";
			1: return "add and subtract";
			2: return "multiply and transpose";
			3: return "scalar multiply";
			4: return "move C to A";
			5: return "quiet commands";
			default: return "unknown";
		endcase
	endfunction

	task automatic reportMismatch(input string msg);
		$display("[FAIL] t=%0d ns: %s", $time, msg);
		errorCount++;
		testErrors++;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			modelC   <= '0;
			expValid <= 1'b0;
		end else begin
			referenceStep(enable, opCode, alt, scaleBits, dataIn, modelA, modelB, modelC,
				nextA, nextB, nextC, nextValid);
			modelA   <= nextA;
			modelB   <= nextB;
			modelC   <= nextC;
			expValid <= nextValid;
		end
	end

	// outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		if (rst) begin
			errorCount  = 0;
			testErrors  = 0;
			testsPassed = 0;
			testsFailed = 0;
		end else begin
			if (outValid !== expValid) begin
				reportMismatch($sformatf("outValid is %b, expected %b", outValid, expValid));
			end else if (expValid && (dataOut !== matrixToBus(modelC))) begin
				reportMismatch($sformatf("dataOut is %h, expected %h",
					dataOut, matrixToBus(modelC)));
			end
			// testEnd spans exactly one falling edge
			if (testEnd) begin
				if (testErrors == 0) begin
					testsPassed++;
					$display("test %0d %s: pass", testIndex, testName(testIndex));
				end else begin
					testsFailed++;
					$display("test %0d %s: %0d mismatches", testIndex, testName(testIndex),
						testErrors);
				end
				testErrors = 0;
			end
		end
	end

	always @(posedge finished) begin
		$display("tests passed %0d, failed %0d, mismatches %0d", testsPassed, testsFailed,
			errorCount);
	end

endmodule

// ==== tb/matrixAluTb.sv ====
// ==========================================================
// Matrix ALU testbench: clock, reset, directed command
// stimulus, watchdog, DUT and checker
// ==========================================================
`timescale 1ns/1ps

module matrixAluTb;
	import matrixPkg::*;

	localparam int ClkPeriod     = 10;
	localparam int ResetCycles   = 16;
	// 34 directed commands plus an idle and a report cycle after each of the six tests
	localparam int CommandCycles = 34 + 2 * 6;
	localparam int TimeoutNs     = (ResetCycles + CommandCycles) * ClkPeriod + 200;

	logic                      clk;
	logic                      rst;
	logic                      enable;
	opcode_e                   opCode;
	alt_e                      alt;
	logic [ScaleBitsWidth-1:0] scaleBits;
	logic [BusWidth-1:0]       dataIn;
	logic [BusWidth-1:0]       dataOut;
	logic                      outValid;
	logic                      testEnd;
	int                        testIndex;
	logic                      finished;
	int                        errorCount;
	int                        seed;

	matrixAlu dut_i (.*);

	matrixAluChecker checker_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#(ClkPeriod / 2) clk = ~clk;
		end
	end

	initial begin
		#(TimeoutNs);
		$display("watchdog timeout: stimulus still running after %0d ns", TimeoutNs);
		$display("ERRORS FOUND");
		$finish;
	end

	// inputs change 1 ns after the rising edge and are taken on the next one
	task automatic driveCycle(
		input logic                      en,
		input opcode_e                   op,
		input alt_e                      al,
		input logic [ScaleBitsWidth-1:0] sb,
		input logic [BusWidth-1:0]       bus
	);
		enable    = en;
		opCode    = op;
		alt       = al;
		scaleBits = sb;
		dataIn    = bus;
		@(posedge clk);
		#1;
	endtask

	task automatic command(input opcode_e op, input alt_e al);
		driveCycle(1'b1, op, al, '0, '0);
	endtask

	task automatic loadMatrix(input alt_e al, input matrix_t m);
		driveCycle(1'b1, LOAD, al, '0, matrixToBus(m));
	endtask

	// the five bit factor is split over alt and scaleBits
	task automatic scaleBy(input logic [4:0] factor);
		driveCycle(1'b1, SCAL_MUL, alt_e'(factor[4:3]), factor[2:0], '0);
	endtask

	task automatic endTest(input int idx);
		driveCycle(1'b0, NO_OP, C_TO_A, '0, '0);
		testIndex = idx;
		testEnd   = 1'b1;
		@(posedge clk);
		#1;
		testEnd = 1'b0;
	endtask

	function automatic matrix_t randomMatrix();
		matrix_t m;
		int      r;
		for (int row = 0; row < MatrixDim; row++) begin
			for (int col = 0; col < MatrixDim; col++) begin
				r = $random(seed);
				m[row][col] = r[15:0];
			end
		end
		return m;
	endfunction

	function automatic matrix_t patternMatrix(input elem_t diag, input elem_t other);
		matrix_t m;
		for (int row = 0; row < MatrixDim; row++) begin
			for (int col = 0; col < MatrixDim; col++) begin
				m[row][col] = (row == col) ? diag : other;
			end
		end
		return m;
	endfunction

	initial begin
		seed      = 20720;
		rst       = 1'b1;
		enable    = 1'b0;
		opCode    = NO_OP;
		alt       = C_TO_A;
		scaleBits = '0;
		dataIn    = '0;
		testEnd   = 1'b0;
		testIndex = 0;
		finished  = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		rst = 1'b0;

		command(LOAD, OUT_TO_BUS);
		endTest(0);

		loadMatrix(WRITE_A, randomMatrix());
		loadMatrix(WRITE_B, randomMatrix());
		command(ADD, OUT_TO_BUS);
		command(SUB, OUT_TO_BUS);
		endTest(1);

		loadMatrix(WRITE_A, randomMatrix());
		loadMatrix(WRITE_B, randomMatrix());
		command(MATR_MUL, OUT_TO_BUS);
		command(TRANSPOSE, OUT_TO_BUS);
		loadMatrix(WRITE_B, patternMatrix(16'd1, 16'd0));
		command(MATR_MUL, OUT_TO_BUS);
		// large elements make every sum and product wrap
		loadMatrix(WRITE_A, patternMatrix(16'hffff, 16'hffff));
		loadMatrix(WRITE_B, patternMatrix(16'h8001, 16'hfff3));
		command(MATR_MUL, OUT_TO_BUS);
		command(ADD, OUT_TO_BUS);
		endTest(2);

		loadMatrix(WRITE_A, randomMatrix());
		scaleBy(5'd21);
		command(LOAD, OUT_TO_BUS);
		command(MATR_MUL, OUT_TO_BUS);
		// a factor of 31 puts OUT_TO_BUS on alt, still without output
		scaleBy(5'd31);
		command(LOAD, OUT_TO_BUS);
		command(MATR_MUL, OUT_TO_BUS);
		endTest(3);

		loadMatrix(WRITE_A, randomMatrix());
		loadMatrix(WRITE_B, randomMatrix());
		command(SUB, WRITE_A);
		command(LOAD, C_TO_A);
		command(ADD, OUT_TO_BUS);
		endTest(4);

		command(NO_OP, OUT_TO_BUS);
		command(START, OUT_TO_BUS);
		driveCycle(1'b0, ADD, OUT_TO_BUS, '0, '0);
		driveCycle(1'b0, LOAD, WRITE_A, '0, matrixToBus(randomMatrix()));
		command(LOAD, OUT_TO_BUS);
		command(TRANSPOSE, WRITE_B);
		command(LOAD, OUT_TO_BUS);
		endTest(5);

		finished = 1'b1;
		#1;
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
src/matrixPkg.sv
src/matrixMultiply.sv
src/matrixElementwise.sv
src/matrixRegisterBank.sv
src/matrixAlu.sv
tb/matrixAluChecker.sv
tb/matrixAluTb.sv

// ==== Makefile ====
# Verilator lint, build and run of the matrix ALU testbench

VERILATOR ?= verilator
TOP       ?= matrixAluTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up as a line of its own
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
